//--- Makefile
TOP := tb_fifo_ctrl_push_credit

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f fifo_ctrl_push_credit.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- fifo_ctrl_push_credit.f
+incdir+rtl
rtl/fifo_data_pkg.sv
rtl/fifo_credit_pkg.sv
rtl/credit_return_fsm.sv
rtl/credit_counter.sv
rtl/fifo_push_ctrl.sv
rtl/fifo_pop_ctrl.sv
rtl/fifo_ram_1r1w.sv
rtl/fifo_ctrl_push_credit.sv
verif/tb_fifo_ctrl_push_credit.sv

//--- rtl/credit_counter.sv
// Counts credits still owed to the sender and returns them one per cycle

`include "fifo_credit_defs.svh"

module credit_counter (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     credit_enable,
  input  logic                     credit_reload,
  input  logic                     push_credit_stall,
  input  logic                     pop_beat,
  input  fifo_credit_pkg::credit_t credit_initial_push,
  input  fifo_credit_pkg::credit_t credit_withhold_push,
  output logic                     push_credit,
  output fifo_credit_pkg::credit_t credit_count_push,
  output fifo_credit_pkg::credit_t credit_available_push
);

  import fifo_credit_pkg::*;

  credit_t count_next;

  // -------------------------------------------------------------------------
  // Withhold and credit release
  // -------------------------------------------------------------------------

  // Withheld credits stay in the pool but cannot be released
  always_comb begin
    if (credit_count_push > credit_withhold_push) begin
      credit_available_push = credit_count_push - credit_withhold_push;
    end else begin
      credit_available_push = '0;
    end
  end

  // At most one credit per cycle, straight from the registered count
  assign push_credit = credit_enable && !push_credit_stall &&
                       (credit_available_push != '0);

  // -------------------------------------------------------------------------
  // Count update
  // -------------------------------------------------------------------------

  always_comb begin
    count_next = credit_count_push;
    if (push_credit && !pop_beat) begin
      count_next = credit_count_push - 1'b1;
    end else if (pop_beat && !push_credit) begin
      // Saturate at the top of the range
      if (credit_count_push != credit_t'(`FIFO_MAX_CREDIT)) begin
        count_next = credit_count_push + 1'b1;
      end
    end
    // Credit given and pop in the same cycle cancel out
  end

  // Reset and reload both restore the initial pool
  always_ff @(posedge clk) begin
    if (reset || credit_reload) begin
      credit_count_push <= credit_initial_push;
    end else begin
      credit_count_push <= count_next;
    end
  end

endmodule : credit_counter

//--- rtl/credit_return_fsm.sv
// Sequences receiver reset, sender reset and normal credit return

module credit_return_fsm (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push_sender_in_reset,
  output logic                           push_receiver_in_reset,
  output logic                           credit_enable,
  output logic                           credit_reload,
  output logic                           flush,
  output fifo_credit_pkg::credit_state_t state
);

  import fifo_credit_pkg::*;

  credit_state_t state_next;

  // -------------------------------------------------------------------------
  // Next state
  // -------------------------------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      // Leave local reset on the first cycle after release
      // Go straight to SENDER_RESET if the far side is still down
      RECV_RESET: begin
        if (push_sender_in_reset) begin
          state_next = SENDER_RESET;
        end else begin
          state_next = ACTIVE;
        end
      end
      // Wait for the sender to come out of reset
      SENDER_RESET: begin
        if (!push_sender_in_reset) begin
          state_next = ACTIVE;
        end
      end
      ACTIVE: begin
        if (push_sender_in_reset) begin
          state_next = SENDER_RESET;
        end
      end
      // Unused encoding, recover through local reset
      default: begin
        state_next = RECV_RESET;
      end
    endcase
  end

  // -------------------------------------------------------------------------
  // State register
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= RECV_RESET;
    end else begin
      state <= state_next;
    end
  end

  // -------------------------------------------------------------------------
  // Outputs, all decoded from the registered state
  // -------------------------------------------------------------------------

  // No path from push_sender_in_reset to push_receiver_in_reset
  assign push_receiver_in_reset = (state == RECV_RESET);

  // Credits only go out in normal operation
  assign credit_enable = (state == ACTIVE);

  // Pool is held at its initial value whenever either side is in reset
  assign credit_reload = (state != ACTIVE);

  // Pop side drains and clears outside of ACTIVE
  assign flush = (state != ACTIVE);

endmodule : credit_return_fsm

//--- rtl/fifo_credit_defs.svh
// Sizing macros shared by the credit-based receive FIFO and its packages

`ifndef FIFO_CREDIT_DEFS_SVH
`define FIFO_CREDIT_DEFS_SVH

// ---------------------------------------------------------------------------
// FIFO geometry
// ---------------------------------------------------------------------------

// Number of entries held by the flop RAM
`define FIFO_DEPTH 8

// Bits per entry
`define FIFO_WIDTH 16

// ---------------------------------------------------------------------------
// Credit loop
// ---------------------------------------------------------------------------

// Largest value the credit counter can hold
// Sized to the FIFO so the sender can fill every slot and no more
`define FIFO_MAX_CREDIT `FIFO_DEPTH

`endif

//--- rtl/fifo_credit_pkg.sv
// Credit-loop types: the credit count and the credit-return FSM states

`include "fifo_credit_defs.svh"

package fifo_credit_pkg;

  // -------------------------------------------------------------------------
  // Credit count
  // -------------------------------------------------------------------------

  // Holds 0 .. FIFO_MAX_CREDIT inclusive
  typedef logic [$clog2(`FIFO_MAX_CREDIT + 1)-1:0] credit_t;

  // -------------------------------------------------------------------------
  // Credit-return FSM
  // -------------------------------------------------------------------------

  // RECV_RESET   local reset, nothing returned
  // SENDER_RESET far side reports reset, pool is reloaded
  // ACTIVE       credits flow and the pop side runs
  typedef enum logic [1:0] {
    RECV_RESET   = 2'd0,
    SENDER_RESET = 2'd1,
    ACTIVE       = 2'd2
  } credit_state_t;

endpackage : fifo_credit_pkg

//--- rtl/fifo_ctrl_push_credit.sv
// Credit-flow receive FIFO with valid/ready pop side over a flop 1R1W RAM

module fifo_ctrl_push_credit (
  input  logic                     clk,
  input  logic                     reset,

  // Push side
  input  logic                     push_sender_in_reset,
  output logic                     push_receiver_in_reset,
  input  logic                     push_credit_stall,
  output logic                     push_credit,
  input  logic                     push_valid,
  input  fifo_data_pkg::entry_t    push_data,

  // Pop side
  input  logic                     pop_ready,
  output logic                     pop_valid,
  output fifo_data_pkg::entry_t    pop_data,

  // Status
  output logic                     full,
  output fifo_data_pkg::count_t    slots,
  output logic                     empty,
  output fifo_data_pkg::count_t    items,

  // Credits
  input  fifo_credit_pkg::credit_t credit_initial_push,
  input  fifo_credit_pkg::credit_t credit_withhold_push,
  output fifo_credit_pkg::credit_t credit_count_push,
  output fifo_credit_pkg::credit_t credit_available_push
);

  import fifo_data_pkg::*;

  // -------------------------------------------------------------------------
  // Credit loop
  // -------------------------------------------------------------------------

  logic credit_enable;
  logic credit_reload;
  logic flush;
  logic push_beat;
  logic pop_beat;

  credit_return_fsm credit_return_fsm (
    .clk,
    .reset,
    .push_sender_in_reset,
    .push_receiver_in_reset,
    .credit_enable,
    .credit_reload,
    .flush,
    // Kept for debug visibility
    .state                  ()
  );

  credit_counter credit_counter (
    .clk,
    .reset,
    .credit_enable,
    .credit_reload,
    .push_credit_stall,
    .pop_beat,
    .credit_initial_push,
    .credit_withhold_push,
    .push_credit,
    .credit_count_push,
    .credit_available_push
  );

  // -------------------------------------------------------------------------
  // Data path
  // -------------------------------------------------------------------------

  logic   push_ctrl_reset;
  logic   ram_wr_valid;
  addr_t  ram_wr_addr;
  entry_t ram_wr_data;
  addr_t  ram_rd_addr;
  entry_t ram_rd_data;

  // Write pointer realigns with the read pointer on every flush
  assign push_ctrl_reset = reset || flush;

  fifo_push_ctrl fifo_push_ctrl (
    .clk,
    .reset        (push_ctrl_reset),
    .push_valid,
    .pop_beat,
    .push_data,
    .push_beat,
    .ram_wr_valid,
    .full,
    .ram_wr_addr,
    .ram_wr_data,
    .slots
  );

  fifo_pop_ctrl fifo_pop_ctrl (
    .clk,
    .reset,
    .flush,
    .pop_ready,
    .push_beat,
    .ram_rd_data,
    .pop_valid,
    .pop_beat,
    .empty,
    .pop_data,
    .ram_rd_addr,
    .items
  );

  fifo_ram_1r1w fifo_ram_1r1w (
    .clk,
    .wr_valid (ram_wr_valid),
    .wr_addr  (ram_wr_addr),
    .rd_addr  (ram_rd_addr),
    .wr_data  (ram_wr_data),
    .rd_data  (ram_rd_data)
  );

endmodule : fifo_ctrl_push_credit

//--- rtl/fifo_data_pkg.sv
// Data-path types for the receive FIFO: entries, RAM addresses and counts

`include "fifo_credit_defs.svh"

package fifo_data_pkg;

  // -------------------------------------------------------------------------
  // Payload
  // -------------------------------------------------------------------------

  // One stored word, same shape on push, RAM and pop
  typedef logic [`FIFO_WIDTH-1:0] entry_t;

  // -------------------------------------------------------------------------
  // Addressing and occupancy
  // -------------------------------------------------------------------------

  // Index into the flop array
  typedef logic [$clog2(`FIFO_DEPTH)-1:0] addr_t;

  // Needs one extra bit so that a full FIFO (DEPTH) is representable
  // Used both for items and for free slots
  typedef logic [$clog2(`FIFO_DEPTH + 1)-1:0] count_t;

endpackage : fifo_data_pkg

//--- rtl/fifo_pop_ctrl.sv
// Pop side of the FIFO: read pointer, item count and valid/ready handshake

`include "fifo_credit_defs.svh"

module fifo_pop_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  flush,
  input  logic                  pop_ready,
  input  logic                  push_beat,
  input  fifo_data_pkg::entry_t ram_rd_data,
  output logic                  pop_valid,
  output logic                  pop_beat,
  output logic                  empty,
  output fifo_data_pkg::entry_t pop_data,
  output fifo_data_pkg::addr_t  ram_rd_addr,
  output fifo_data_pkg::count_t items
);

  import fifo_data_pkg::*;

  addr_t rd_ptr;

  // -------------------------------------------------------------------------
  // Handshake
  // -------------------------------------------------------------------------

  // Suppressed in the first flush cycle, before the count has cleared
  assign pop_valid = (items != '0) && !flush;
  assign pop_beat  = pop_valid && pop_ready;
  assign empty     = (items == '0);

  // -------------------------------------------------------------------------
  // Read port
  // -------------------------------------------------------------------------

  // Zero-latency read, head of queue is always on pop_data
  // Holds while stalled because rd_ptr only moves on a beat
  assign ram_rd_addr = rd_ptr;
  assign pop_data    = ram_rd_data;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;
    end else if (pop_beat) begin
      if (rd_ptr == addr_t'(`FIFO_DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Item count
  // -------------------------------------------------------------------------

  // A push is visible here one edge later, giving 1 cycle cut-through
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      items <= '0;
    end else begin
      case ({push_beat, pop_beat})
        2'b10:   items <= items + 1'b1;
        2'b01:   items <= items - 1'b1;
        default: items <= items;
      endcase
    end
  end

endmodule : fifo_pop_ctrl

//--- rtl/fifo_push_ctrl.sv
// Push side of the FIFO: write pointer, RAM write port and free slots

`include "fifo_credit_defs.svh"

module fifo_push_ctrl (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push_valid,
  input  logic                  pop_beat,
  input  fifo_data_pkg::entry_t push_data,
  output logic                  push_beat,
  output logic                  ram_wr_valid,
  output logic                  full,
  output fifo_data_pkg::addr_t  ram_wr_addr,
  output fifo_data_pkg::entry_t ram_wr_data,
  output fifo_data_pkg::count_t slots
);

  import fifo_data_pkg::*;

  addr_t wr_ptr;

  // -------------------------------------------------------------------------
  // Write port
  // -------------------------------------------------------------------------

  // Credit protocol has no ready, so every valid is a beat
  assign push_beat = push_valid;

  // Same-cycle write into the flop array
  assign ram_wr_valid = push_beat;
  assign ram_wr_addr  = wr_ptr;
  assign ram_wr_data  = push_data;

  // Wraps after the last entry
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (push_beat) begin
      if (wr_ptr == addr_t'(`FIFO_DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // -------------------------------------------------------------------------
  // Free-slot accounting
  // -------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      slots <= count_t'(`FIFO_DEPTH);
    end else begin
      case ({push_beat, pop_beat})
        2'b10:   slots <= slots - 1'b1;
        2'b01:   slots <= slots + 1'b1;
        default: slots <= slots;
      endcase
    end
  end

  assign full = (slots == '0);

endmodule : fifo_push_ctrl

//--- rtl/fifo_ram_1r1w.sv
// Flop array with one synchronous write port and one combinational read port

`include "fifo_credit_defs.svh"

module fifo_ram_1r1w (
  input  logic                  clk,
  input  logic                  wr_valid,
  input  fifo_data_pkg::addr_t  wr_addr,
  input  fifo_data_pkg::addr_t  rd_addr,
  input  fifo_data_pkg::entry_t wr_data,
  output fifo_data_pkg::entry_t rd_data
);

  import fifo_data_pkg::*;

  // Storage, contents are don't-care until written
  entry_t mem [`FIFO_DEPTH];

  // Write on the rising edge
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read with no latency
  assign rd_data = mem[rd_addr];

endmodule : fifo_ram_1r1w

//--- verif/fifo_input_vectors.txt
// C push pop_ready stall withhold sender_reset data : one cycle of stimulus, hex
// E data : expected pop words in order, 0000 stands for a randomly chosen word
C 0 0 0 0 0 0000
C 0 0 0 0 0 0000
C 1 0 0 0 0 1111
C 1 0 0 0 0 2222
C 1 0 1 0 0 3333
C 1 0 1 0 0 4444
C 1 0 0 4 0 0000
C 1 0 0 4 0 5555
C 0 1 0 4 0 0000
C 0 1 0 4 0 0000
C 1 0 0 0 0 0000
C 1 1 0 0 0 6666
C 1 1 0 0 0 7777
C 0 1 0 0 0 0000
C 0 0 0 0 1 0000
C 0 0 0 0 1 0000
C 0 0 0 0 1 0000
C 0 1 0 0 0 0000
C 0 1 0 0 0 0000
C 1 1 0 0 0 8888
C 1 1 0 0 0 9999
C 1 1 0 0 0 aaaa
C 0 1 0 0 0 0000
E 1111
E 2222
E 3333
E 5555
E 0000
E 8888
E 9999
E aaaa

//--- verif/tb_fifo_ctrl_push_credit.sv
// Vector-driven testbench for the credit-flow receive FIFO with sender model and scoreboard

`include "fifo_credit_defs.svh"

module tb_fifo_ctrl_push_credit;

  import fifo_data_pkg::*;
  import fifo_credit_pkg::*;

  localparam int DEPTH        = `FIFO_DEPTH;
  localparam int RESET_CYCLES = 5;
  localparam int DRAIN_MARGIN = 50;

  // -------------------------------------------------------------------------
  // DUT and clock
  // -------------------------------------------------------------------------

  logic    clk;
  logic    reset;
  logic    push_sender_in_reset;
  logic    push_receiver_in_reset;
  logic    push_credit_stall;
  logic    push_credit;
  logic    push_valid;
  entry_t  push_data;
  logic    pop_ready;
  logic    pop_valid;
  entry_t  pop_data;
  logic    full;
  count_t  slots;
  logic    empty;
  count_t  items;
  credit_t credit_initial_push;
  credit_t credit_withhold_push;
  credit_t credit_count_push;
  credit_t credit_available_push;

  fifo_ctrl_push_credit DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // One queue per vector column
  logic    vec_push [$];
  logic    vec_ready [$];
  logic    vec_stall [$];
  credit_t vec_withhold [$];
  logic    vec_sender_rst [$];
  entry_t  vec_data [$];
  entry_t  exp_words [$];

  // Sender model and scoreboard
  entry_t  scoreboard [$];
  int      sender_credits;
  int      exp_idx;
  logic    prev_sender_rst;
  logic    first_cycle;
  string   test_name;
  int      cycle_count = 0;
  int      cycle_limit = 0;

  // -------------------------------------------------------------------------
  // Failure reporting and compare tasks
  // -------------------------------------------------------------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_entry(input string what, input entry_t expected, input entry_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s %s: expected %h, actual %h",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_count(input string what, input count_t expected, input count_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_credit(input string what, input credit_t expected,
                              input credit_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                          test_name, what, expected, actual));
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR %s %s: expected %b, actual %b",
                          test_name, what, expected, actual));
    end
  endtask

  // -------------------------------------------------------------------------
  // Vector file
  // -------------------------------------------------------------------------

  task automatic load_vectors();
    int    fd;
    int    fields;
    int    col [6];
    string line;
    string rest;

    fd = $fopen("verif/fifo_input_vectors.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the vector file verif/fifo_input_vectors.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Blank lines and // comments carry no record
      if (line.len() > 1 && line.substr(0, 1) != "//") begin
        rest = line.substr(1, line.len() - 1);
        if (line.getc(0) == "C") begin
          fields = $sscanf(rest, "%h %h %h %h %h %h",
                           col[0], col[1], col[2], col[3], col[4], col[5]);
          if (fields != 6) begin
            abort_run({"a cycle record in the vector file is malformed: ", line});
          end
          vec_push.push_back(col[0][0]);
          vec_ready.push_back(col[1][0]);
          vec_stall.push_back(col[2][0]);
          vec_withhold.push_back(credit_t'(col[3]));
          vec_sender_rst.push_back(col[4][0]);
          vec_data.push_back(entry_t'(col[5]));
        end else if (line.getc(0) == "E") begin
          fields = $sscanf(rest, "%h", col[0]);
          if (fields != 1) begin
            abort_run({"an expected-word record is malformed: ", line});
          end
          exp_words.push_back(entry_t'(col[0]));
        end else begin
          abort_run({"the vector file holds an unknown record: ", line});
        end
      end
    end
    $fclose(fd);
    if (vec_push.size() == 0) begin
      abort_run("the vector file holds no cycle records");
    end
  endtask

  // -------------------------------------------------------------------------
  // Drive each cycle at the rising edge and check it at the falling edge
  // -------------------------------------------------------------------------

  task automatic run_cycle(input logic push_req, input logic ready, input logic stall,
                           input credit_t withhold, input logic sender_rst,
                           input entry_t data);
    logic   do_push;
    logic   flush_exp;
    int     owed;
    int     avail;
    entry_t word;

    @(posedge clk);
    // Sender pushes only against a credit it already holds
    do_push = push_req && !sender_rst && (sender_credits > 0);
    word    = data;
    if (do_push && data == '0) begin
      word = entry_t'($urandom);
    end
    if (first_cycle) begin
      reset <= 1'b0;
    end
    push_valid           <= do_push;
    push_data            <= word;
    pop_ready            <= ready;
    push_credit_stall    <= stall;
    credit_withhold_push <= withhold;
    push_sender_in_reset <= sender_rst;

    @(negedge clk);
    // FSM lags push_sender_in_reset by one edge and leaves local reset one edge late
    flush_exp = first_cycle || prev_sender_rst;
    // Credits still owed = pool minus what the sender holds and what sits in the FIFO
    owed  = DEPTH - sender_credits - scoreboard.size();
    avail = (owed > withhold) ? owed - withhold : 0;

    check_flag("push_receiver_in_reset", first_cycle, push_receiver_in_reset);
    check_count("items", count_t'(scoreboard.size()), items);
    check_count("slots", count_t'(DEPTH - scoreboard.size()), slots);
    check_flag("empty", scoreboard.size() == 0, empty);
    check_flag("full", scoreboard.size() == DEPTH, full);
    check_flag("pop_valid", !flush_exp && scoreboard.size() != 0, pop_valid);
    check_flag("push_credit", !flush_exp && !stall && avail != 0, push_credit);
    if (!flush_exp) begin
      check_credit("credit_count_push", credit_t'(owed), credit_count_push);
      check_credit("credit_available_push", credit_t'(avail), credit_available_push);
    end

    // Head word must hold while stalled and match on every beat
    if (pop_valid) begin
      check_entry("pop_data vs scoreboard", scoreboard[0], pop_data);
    end
    if (pop_valid && ready) begin
      if (exp_idx >= exp_words.size()) begin
        abort_run("the FIFO popped more words than the vector file expects");
      end
      if (exp_words[exp_idx] != '0) begin
        check_entry("pop_data vs expected", exp_words[exp_idx], pop_data);
      end
      exp_idx++;
      void'(scoreboard.pop_front());
    end

    // Fold this cycle's events into the model
    if (push_credit && !sender_rst) begin
      sender_credits++;
    end
    if (do_push) begin
      scoreboard.push_back(word);
      sender_credits--;
    end
    if (flush_exp) begin
      scoreboard.delete();
    end
    // Sender drops every credit it held when it goes into reset
    if (sender_rst) begin
      sender_credits = 0;
    end
    prev_sender_rst = sender_rst;
    first_cycle     = 1'b0;
  endtask

  // -------------------------------------------------------------------------
  // Timeout
  // -------------------------------------------------------------------------

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the FIFO and credits never drained",
                          cycle_count));
    end
  end

  // -------------------------------------------------------------------------
  // Main sequence
  // -------------------------------------------------------------------------

  initial begin
    void'($urandom(32'h9fc4c291));
    reset                <= 1'b1;
    push_sender_in_reset <= 1'b0;
    push_credit_stall    <= 1'b0;
    push_valid           <= 1'b0;
    push_data            <= '0;
    pop_ready            <= 1'b0;
    credit_initial_push  <= credit_t'(DEPTH);
    credit_withhold_push <= '0;
    sender_credits  = 0;
    exp_idx         = 0;
    prev_sender_rst = 1'b0;
    first_cycle     = 1'b1;

    load_vectors();
    cycle_limit = RESET_CYCLES + vec_push.size() + DRAIN_MARGIN;

    // Outputs quiet while the receiver is held in reset
    // The last reset edge is the first vector cycle, where reset is released
    test_name = "reset";
    repeat (RESET_CYCLES - 1) begin
      @(posedge clk);
      @(negedge clk);
      check_flag("push_credit", 1'b0, push_credit);
      check_flag("pop_valid", 1'b0, pop_valid);
      check_flag("push_receiver_in_reset", 1'b1, push_receiver_in_reset);
    end

    for (int i = 0; i < vec_push.size(); i++) begin
      test_name = $sformatf("vector %0d", i);
      run_cycle(vec_push[i], vec_ready[i], vec_stall[i], vec_withhold[i],
                vec_sender_rst[i], vec_data[i]);
    end

    // Pop what is left and let the whole pool flow back to the sender
    test_name = "drain";
    while (exp_idx < exp_words.size() || scoreboard.size() != 0 ||
           sender_credits != DEPTH) begin
      run_cycle(1'b0, 1'b1, 1'b0, '0, 1'b0, '0);
    end

    $display("sim passed");
    $finish;
  end

endmodule : tb_fifo_ctrl_push_credit
